// ==== Makefile ====
# Verilator build and run of the vector register file testbench

SRCS := $(shell cat sim.f)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
obj_dir/Vvrf_tb: sim.f $(SRCS)
	verilator --binary --top-module vrf_tb -f sim.f -o Vvrf_tb

run: obj_dir/Vvrf_tb
	./obj_dir/Vvrf_tb | tee sim.log

# pass or fail is read back from the log
check: run
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/vrf_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// directed table then 200 random requests against a shadow register model
// resp is expected exactly 3 cycles after each request with no gaps
////////////////////////////////////////////////////////////////////////////
module vrf_tb
  import vrf_cfg_pkg::*, vrf_types_pkg::*;
();

  localparam int NUM_DIR        = 20;
  localparam int NUM_RAND       = 200;
  localparam int TIMEOUT_CYCLES = (NUM_DIR + NUM_RAND + 20) * 2;

  logic      CLK;
  logic      nRST;
  vrf_req_t  req;
  vrf_resp_t resp;

  vrf_req_t  tbl_req [NUM_DIR];
  vrf_resp_t tbl_exp [NUM_DIR];
  int        n_rows;

  vrf_resp_t exp_q[$];       // one entry per cycle whether idle or valid
  vreg_u     shadow [NUM_VREGS];
  logic [31:0] rng_state;
  int        checks;
  int        value_errors;
  int        valid_errors;
  int        cycles;

  vrf_top UUT (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .resp (resp)
  );

  always #5 CLK = ~CLK;

  // run limit
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic vrf_req_t mk_req(
    input logic        wen,
    input sew_t        sew,
    input int          vl,
    input int          vd,
    input int          vd_off,
    input logic [31:0] wd0,
    input logic [31:0] wd1,
    input int          vs1,
    input int          vs1_off,
    input int          vs2,
    input int          vs2_off
  );
    vrf_req_t r;
    r           = '0;
    r.valid     = 1'b1;
    r.wen       = wen;
    r.sew       = sew;
    r.vl        = VL_W'(vl);
    r.vd        = VREG_W'(vd);
    r.vd_off    = EOFF_W'(vd_off);
    r.w_data[0] = wd0;
    r.w_data[1] = wd1;
    r.vs1       = VREG_W'(vs1);
    r.vs1_off   = EOFF_W'(vs1_off);
    r.vs2       = VREG_W'(vs2);
    r.vs2_off   = EOFF_W'(vs2_off);
    return r;
  endfunction

  function automatic vrf_resp_t mk_exp(
    input logic [31:0] a0,
    input logic [31:0] a1,
    input logic [31:0] b0,
    input logic [31:0] b1,
    input logic [1:0]  m           // {lane 1, lane 0}
  );
    vrf_resp_t e;
    e             = '0;
    e.valid       = 1'b1;
    e.vs1_data[0] = a0;
    e.vs1_data[1] = a1;
    e.vs2_data[0] = b0;
    e.vs2_data[1] = b1;
    e.mask        = m;
    return e;
  endfunction

  task automatic add_row(input vrf_req_t r, input vrf_resp_t e);
    tbl_req[n_rows] = r;
    tbl_exp[n_rows] = e;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    // reads after reset
    add_row(mk_req(0, SEW32, 64, 0, 0, 0, 0, 5, 0, 31, 6), mk_exp(0, 0, 0, 0, 2'b00));
    add_row(mk_req(0, SEW8, 128, 0, 40, 0, 0, 17, 100, 2, 15), mk_exp(0, 0, 0, 0, 2'b00));
    // SEW32 write across the v4/v5 boundary
    add_row(mk_req(1, SEW32, 8, 4, 3, 32'hA1B2C3D4, 32'h11223344, 4, 3, 5, 0),
            mk_exp(0, 0, 0, 0, 2'b00));
    add_row(mk_req(0, SEW32, 8, 0, 0, 0, 0, 4, 3, 5, 0),
            mk_exp(32'hA1B2C3D4, 32'h11223344, 32'h11223344, 0, 2'b00));
    // bytes into v8 then read back as a word and as halfwords
    add_row(mk_req(1, SEW8, 16, 8, 0, 32'hAAAAAA78, 32'hBBBBBB56, 8, 0, 9, 0),
            mk_exp(0, 0, 0, 0, 2'b00));
    add_row(mk_req(1, SEW8, 16, 8, 2, 32'hCCCCCC34, 32'hDDDDDD12, 8, 0, 8, 2),
            mk_exp(32'h78, 32'h56, 0, 0, 2'b00));
    add_row(mk_req(0, SEW32, 8, 0, 0, 0, 0, 8, 0, 4, 3),
            mk_exp(32'h12345678, 0, 32'hA1B2C3D4, 32'h11223344, 2'b00));
    add_row(mk_req(1, SEW16, 16, 10, 7, 32'h9999BEEF, 32'h8888CAFE, 10, 7, 8, 0),
            mk_exp(0, 0, 32'h5678, 32'h1234, 2'b00));
    add_row(mk_req(0, SEW8, 32, 0, 0, 0, 0, 10, 14, 10, 16),
            mk_exp(32'hEF, 32'hBE, 32'hFE, 32'hCA, 2'b00));
    // tail lanes with vl = vd_off + 1
    add_row(mk_req(1, SEW32, 3, 12, 2, 32'h0BADF00D, 32'hFEEDFACE, 12, 2, 12, 3),
            mk_exp(0, POISON1, POISON0, POISON1, 2'b00));
    add_row(mk_req(0, SEW32, 8, 0, 0, 0, 0, 12, 2, 12, 0),
            mk_exp(32'h0BADF00D, 0, 0, 0, 2'b00));
    add_row(mk_req(1, SEW8, 0, 0, 0, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 0, 3, 5),
            mk_exp(POISON0, POISON1, POISON0, POISON1, 2'b00));
    // v0 pattern then mask bits from several bytes
    add_row(mk_req(1, SEW32, 4, 0, 0, 32'hA5C30F96, 32'h12487EDB, 0, 0, 0, 2),
            mk_exp(0, 0, 0, 0, 2'b00));
    add_row(mk_req(1, SEW32, 4, 0, 2, 32'hF0F01234, 32'h80000001, 0, 0, 0, 2),
            mk_exp(32'hA5C30F96, 32'h12487EDB, 0, 0, 2'b01));
    add_row(mk_req(0, SEW32, 4, 0, 11, 0, 0, 0, 0, 0, 2),
            mk_exp(32'hA5C30F96, 32'h12487EDB, 32'hF0F01234, 32'h80000001, 2'b01));
    add_row(mk_req(0, SEW16, 16, 0, 31, 0, 0, 0, 0, 0, 7),
            mk_exp(32'h0F96, 32'hA5C3, 32'h8000, 0, 2'b11));
    add_row(mk_req(0, SEW8, 16, 0, 126, 0, 0, 0, 14, 0, 4),
            mk_exp(0, 32'h80, 32'hDB, 32'h7E, 2'b10));
    add_row(mk_req(0, SEW32, 4, 0, 73, 0, 0, 0, 3, 0, 1),
            mk_exp(32'h80000001, POISON1, 32'h12487EDB, 32'hF0F01234, 2'b01));
    // group wraps from v31 into v0
    add_row(mk_req(1, SEW32, 8, 31, 3, 32'hCAFED00D, 32'h5EEDBEEF, 31, 3, 0, 0),
            mk_exp(0, 32'hA5C30F96, 32'hA5C30F96, 32'h12487EDB, 2'b10));
    add_row(mk_req(0, SEW32, 8, 0, 0, 0, 0, 31, 3, 0, 0),
            mk_exp(32'hCAFED00D, 32'h5EEDBEEF, 32'h5EEDBEEF, 32'h12487EDB, 2'b11));
  endtask

  function automatic int per_reg(input sew_t sew);
    case (sew)
      SEW32:   return 4;
      SEW16:   return 8;
      default: return 16;
    endcase
  endfunction

  // expected read of one lane from the shadow
  function automatic logic [31:0] model_read(
    input logic [VREG_W-1:0] base,
    input int                off,
    input int                k,
    input sew_t              sew,
    input int                vl,
    input logic [31:0]       poison
  );
    int    e;
    int    r;
    int    pos;
    vreg_u v;
    e = off + k;
    if (e >= vl) return poison;
    r   = (int'(base) + e / per_reg(sew)) % NUM_VREGS;
    pos = e % per_reg(sew);
    v   = shadow[r];
    case (sew)
      SEW32:   return v.w[pos];
      SEW16:   return {16'h0, v.h[pos]};
      default: return {24'h0, v.b[pos]};
    endcase
  endfunction

  function automatic logic model_mask(input logic [EOFF_W-1:0] vd_off, input int k);
    logic [EOFF_W-1:0] idx;
    logic [127:0]      v0;
    idx = vd_off + EOFF_W'(k);    // wraps at 128 elements
    v0  = shadow[0];
    return v0[idx];
  endfunction

  task automatic shadow_write(input vrf_req_t r);
    int e;
    int ri;
    int pos;
    for (int k = 0; k < LANES; k++) begin
      e = int'(r.vd_off) + k;
      if (r.valid && r.wen && e < int'(r.vl)) begin
        ri  = (int'(r.vd) + e / per_reg(r.sew)) % NUM_VREGS;
        pos = e % per_reg(r.sew);
        case (r.sew)
          SEW32:   shadow[ri].w[pos] = r.w_data[k];
          SEW16:   shadow[ri].h[pos] = r.w_data[k][15:0];
          default: shadow[ri].b[pos] = r.w_data[k][7:0];
        endcase
      end
    end
  endtask

  task automatic compare_word(input string port, input logic [31:0] e, input logic [31:0] a);
    if (a !== e) begin
      value_errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, port, e, a);
    end
  endtask

  task automatic check_resp(input vrf_resp_t e);
    checks++;
    if (resp.valid !== e.valid) begin
      valid_errors++;
      if (e.valid)
        $display("at time %0t a response was due but resp.valid stayed low", $time);
      else
        $display("at time %0t resp.valid went high with no request due", $time);
    end else if (e.valid) begin
      for (int k = 0; k < LANES; k++) begin
        compare_word($sformatf("vs1_data[%0d]", k), e.vs1_data[k], resp.vs1_data[k]);
        compare_word($sformatf("vs2_data[%0d]", k), e.vs2_data[k], resp.vs2_data[k]);
      end
      if (resp.mask !== e.mask) begin
        value_errors++;
        $display("Error at %0t: mask expected %b, got %b", $time, e.mask, resp.mask);
      end
    end
  endtask

  // check what left the pipe then drive the next request
  task automatic apply(input vrf_req_t r, input vrf_resp_t e);
    @(posedge CLK);
    #1;
    if (exp_q.size() >= 3) check_resp(exp_q.pop_front());
    req = r;
    exp_q.push_back(e);
    shadow_write(r);
  endtask

  function automatic logic [31:0] rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // small register set so writes and reads collide
  task automatic make_random(output vrf_req_t r);
    logic [31:0] x;
    x         = rand_word();
    r         = '0;
    r.valid   = 1'b1;
    r.wen     = (x[1:0] != 2'd0);
    case (x[3:2])
      2'd0:    r.sew = SEW8;
      2'd1:    r.sew = SEW16;
      default: r.sew = SEW32;
    endcase
    r.vd      = {3'b000, x[5:4]};
    r.vs1     = {3'b000, x[7:6]};
    r.vs2     = {3'b000, x[9:8]};
    r.vd_off  = {x[31], 2'b00, x[13:10]};
    r.vs1_off = {3'b000, x[17:14]};
    r.vs2_off = {3'b000, x[21:18]};
    r.vl      = (x[24:22] == 3'd0) ? {3'b000, x[29:25]} : 8'd128;
    r.w_data[0] = rand_word();
    r.w_data[1] = rand_word();
  endtask

  initial begin
    vrf_req_t  r;
    vrf_resp_t e;
    vrf_resp_t idle;
    CLK          = 1'b0;
    nRST         = 1'b0;
    req          = '0;
    rng_state    = 32'd58938;
    checks       = 0;
    value_errors = 0;
    valid_errors = 0;
    cycles       = 0;
    idle         = '0;
    for (int i = 0; i < NUM_VREGS; i++) shadow[i] = '0;
    build_table();

    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    // resp.valid stays low while nothing is in flight
    repeat (3) exp_q.push_back(idle);

    for (int i = 0; i < n_rows; i++) begin
      apply(tbl_req[i], tbl_exp[i]);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      make_random(r);
      e = '0;
      e.valid = 1'b1;
      for (int k = 0; k < LANES; k++) begin
        e.vs1_data[k] = model_read(r.vs1, int'(r.vs1_off), k, r.sew, int'(r.vl),
                                   (k == 0) ? POISON0 : POISON1);
        e.vs2_data[k] = model_read(r.vs2, int'(r.vs2_off), k, r.sew, int'(r.vl),
                                   (k == 0) ? POISON0 : POISON1);
        e.mask[k]     = model_mask(r.vd_off, k);
      end
      apply(r, e);      // shadow updated after the reads above
    end

    // drain plus a few idle cycles
    repeat (6) apply('0, idle);

    $display("checks %0d, value errors %0d, valid errors %0d",
             checks, value_errors, valid_errors);
    if (value_errors == 0 && valid_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/vrf_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// stage 2, register storage with two write lanes and four read lanes
// reads see the contents before this request's write, lane 1 wins a clash
////////////////////////////////////////////////////////////////////////////
module vrf_bank
  import vrf_cfg_pkg::*, vrf_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  vrf_addr_t addr,
  output vrf_raw_t  raw
);

  vreg_u          regs [NUM_VREGS];
  vrf_raw_t       raw_d;
  logic [2:0]     wr_bytes;
  logic [127:0]   v0_bits;

  assign wr_bytes = sew_bytes(addr.sew);
  assign v0_bits  = regs[0];

  // four bytes from bpos up, wrapping inside the register
  function automatic logic [ELEM_W-1:0] gather(
    input vreg_u             r,
    input logic [BPOS_W-1:0] bpos
  );
    logic [ELEM_W-1:0] word;
    for (int j = 0; j < ELEM_W / 8; j++) begin
      word[8*j +: 8] = r.b[BPOS_W'(bpos + j)];
    end
    return word;
  endfunction

  // lane writes, byte by byte
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_VREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int k = 0; k < LANES; k++) begin     // later lane overrides
        if (addr.wr_en[k]) begin
          for (int j = 0; j < ELEM_W / 8; j++) begin
            if (j < int'(wr_bytes)) begin
              regs[addr.wr_loc[k].reg_idx].b[BPOS_W'(addr.wr_loc[k].bpos + j)] <=
                addr.w_data[k][8*j +: 8];
            end
          end
        end
      end
    end
  end

  always_comb begin
    raw_d          = '0;
    raw_d.valid    = addr.valid;
    raw_d.sew      = addr.sew;
    raw_d.vs1_live = addr.vs1_live;
    raw_d.vs2_live = addr.vs2_live;
    for (int k = 0; k < LANES; k++) begin
      raw_d.vs1_raw[k] = gather(regs[addr.vs1_loc[k].reg_idx], addr.vs1_loc[k].bpos);
      raw_d.vs2_raw[k] = gather(regs[addr.vs2_loc[k].reg_idx], addr.vs2_loc[k].bpos);
      raw_d.mask[k]    = v0_bits[addr.mask_idx[k]];     // one bit per element
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      raw <= '0;
    end else begin
      raw <= raw_d;
    end
  end

endmodule

// ==== hw/vrf_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// register file geometry and element width encoding
// one sew per request, vl counts elements of the addressed group
////////////////////////////////////////////////////////////////////////////
package vrf_cfg_pkg;

  localparam int NUM_VREGS = 32;
  localparam int VLENB     = 16;            // bytes per register
  localparam int LANES     = 2;             // elements per port per request
  localparam int EOFF_W    = 7;             // 128 elements of a group at SEW8
  localparam int VREG_W    = 5;
  localparam int VL_W      = EOFF_W + 1;    // vl and element index
  localparam int BPOS_W    = $clog2(VLENB);
  localparam int ELEM_W    = 32;

  // read words returned for tail lanes
  localparam logic [ELEM_W-1:0] POISON0 = 32'hDED0DED0;
  localparam logic [ELEM_W-1:0] POISON1 = 32'hDED1DED1;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // bytes per element
  function automatic logic [2:0] sew_bytes(input sew_t sew);
    case (sew)
      SEW16:   return 3'd2;
      SEW32:   return 3'd4;
      default: return 3'd1;
    endcase
  endfunction

endpackage

// ==== hw/vrf_elem_addr.sv ====
////////////////////////////////////////////////////////////////////////////
// stage 1, element offsets to register index and byte position
// register index wraps mod 32, group bounds are not checked
////////////////////////////////////////////////////////////////////////////
module vrf_elem_addr
  import vrf_cfg_pkg::*, vrf_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  vrf_req_t  req,
  output vrf_addr_t addr
);

  vrf_addr_t addr_d;

  // element e of the group based at base
  function automatic elem_loc_t locate(
    input logic [VREG_W-1:0] base,
    input logic [VL_W-1:0]   e,
    input sew_t              sew
  );
    logic [VL_W-1:0] step;
    elem_loc_t       loc;
    case (sew)
      SEW16: begin
        step     = e >> (BPOS_W - 1);         // 8 halfwords per register
        loc.bpos = {e[BPOS_W-2:0], 1'b0};
      end
      SEW32: begin
        step     = e >> (BPOS_W - 2);
        loc.bpos = {e[BPOS_W-3:0], 2'b00};
      end
      default: begin
        step     = e >> BPOS_W;
        loc.bpos = e[BPOS_W-1:0];
      end
    endcase
    loc.reg_idx = base + step[VREG_W-1:0];    // wraps past v31
    return loc;
  endfunction

  always_comb begin
    logic [VL_W-1:0] e_vd;
    logic [VL_W-1:0] e_vs1;
    logic [VL_W-1:0] e_vs2;
    addr_d        = '0;
    addr_d.valid  = req.valid;
    addr_d.sew    = req.sew;
    addr_d.w_data = req.w_data;
    for (int k = 0; k < LANES; k++) begin
      e_vd  = VL_W'(req.vd_off) + VL_W'(k);
      e_vs1 = VL_W'(req.vs1_off) + VL_W'(k);
      e_vs2 = VL_W'(req.vs2_off) + VL_W'(k);

      addr_d.wr_loc[k] = locate(req.vd, e_vd, req.sew);
      addr_d.wr_en[k]  = req.valid & req.wen & (e_vd < req.vl);

      addr_d.vs1_loc[k]  = locate(req.vs1, e_vs1, req.sew);
      addr_d.vs1_live[k] = e_vs1 < req.vl;
      addr_d.vs2_loc[k]  = locate(req.vs2, e_vs2, req.sew);
      addr_d.vs2_live[k] = e_vs2 < req.vl;

      // mask bit follows the destination element
      addr_d.mask_idx[k] = req.vd_off + EOFF_W'(k);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr <= '0;
    end else begin
      addr <= addr_d;
    end
  end

endmodule

// ==== hw/vrf_read_format.sv ====
////////////////////////////////////////////////////////////////////////////
// stage 3, zero extension by sew and tail poison on read lanes
// tail words are DED0DED0 for lane 0 and DED1DED1 for lane 1
////////////////////////////////////////////////////////////////////////////
module vrf_read_format
  import vrf_cfg_pkg::*, vrf_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  vrf_raw_t  raw,
  output vrf_resp_t resp
);

  vrf_resp_t resp_d;

  function automatic logic [ELEM_W-1:0] fmt_lane(
    input logic [ELEM_W-1:0] raw_w,
    input logic              live,
    input sew_t              sew,
    input logic [ELEM_W-1:0] poison
  );
    logic [ELEM_W-1:0] keep;
    for (int j = 0; j < ELEM_W / 8; j++) begin
      keep[8*j +: 8] = (j < int'(sew_bytes(sew))) ? 8'hff : 8'h00;
    end
    return live ? (raw_w & keep) : poison;
  endfunction

  always_comb begin
    logic [ELEM_W-1:0] poison;
    resp_d       = '0;
    resp_d.valid = raw.valid;
    resp_d.mask  = raw.mask;                 // mask is not width dependent
    for (int k = 0; k < LANES; k++) begin
      poison            = (k == 0) ? POISON0 : POISON1;
      resp_d.vs1_data[k] = fmt_lane(raw.vs1_raw[k], raw.vs1_live[k], raw.sew, poison);
      resp_d.vs2_data[k] = fmt_lane(raw.vs2_raw[k], raw.vs2_live[k], raw.sew, poison);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resp <= '0;
    end else begin
      resp <= resp_d;
    end
  end

endmodule

// ==== hw/vrf_top.sv ====
////////////////////////////////////////////////////////////////////////////
// vector register file, fixed 3 cycle latency from req to resp
// a request may enter every cycle, later requests see earlier writes
////////////////////////////////////////////////////////////////////////////
module vrf_top
  import vrf_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  vrf_req_t  req,
  output vrf_resp_t resp
);

  vrf_addr_t addr;   // stage 1 to 2
  vrf_raw_t  raw;    // stage 2 to 3

  vrf_elem_addr u_elem_addr (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .addr (addr)
  );

  // storage, write commits here
  vrf_bank u_bank (
    .CLK  (CLK),
    .nRST (nRST),
    .addr (addr),
    .raw  (raw)
  );

  vrf_read_format u_read_format (
    .CLK  (CLK),
    .nRST (nRST),
    .raw  (raw),
    .resp (resp)
  );

endmodule

// ==== hw/vrf_types_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// request, pipeline stage and response structs of the register file
// every struct carries valid as a one cycle strobe, no back-pressure
////////////////////////////////////////////////////////////////////////////
package vrf_types_pkg;
  import vrf_cfg_pkg::*;

  // one vector register seen as bytes, halfwords or words
  typedef union packed {
    logic [VLENB-1:0][7:0]    b;
    logic [VLENB/2-1:0][15:0] h;
    logic [VLENB/4-1:0][31:0] w;
  } vreg_u;

  typedef struct packed {
    logic                         valid;
    logic                         wen;
    sew_t                         sew;
    logic [VL_W-1:0]              vl;
    logic [VREG_W-1:0]            vd;
    logic [EOFF_W-1:0]            vd_off;
    logic [LANES-1:0][ELEM_W-1:0] w_data;
    logic [VREG_W-1:0]            vs1;
    logic [EOFF_W-1:0]            vs1_off;
    logic [VREG_W-1:0]            vs2;
    logic [EOFF_W-1:0]            vs2_off;
  } vrf_req_t;

  // where one element sits
  typedef struct packed {
    logic [VREG_W-1:0] reg_idx;
    logic [BPOS_W-1:0] bpos;        // first byte of the element
  } elem_loc_t;

  typedef struct packed {
    logic                         valid;
    sew_t                         sew;
    elem_loc_t [LANES-1:0]        wr_loc;
    logic [LANES-1:0]             wr_en;
    logic [LANES-1:0][ELEM_W-1:0] w_data;
    elem_loc_t [LANES-1:0]        vs1_loc;
    logic [LANES-1:0]             vs1_live;
    elem_loc_t [LANES-1:0]        vs2_loc;
    logic [LANES-1:0]             vs2_live;
    logic [LANES-1:0][EOFF_W-1:0] mask_idx;   // bit index into v0
  } vrf_addr_t;

  typedef struct packed {
    logic                         valid;
    sew_t                         sew;
    logic [LANES-1:0][ELEM_W-1:0] vs1_raw;    // not yet width masked
    logic [LANES-1:0][ELEM_W-1:0] vs2_raw;
    logic [LANES-1:0]             vs1_live;
    logic [LANES-1:0]             vs2_live;
    logic [LANES-1:0]             mask;
  } vrf_raw_t;

  typedef struct packed {
    logic                         valid;
    logic [LANES-1:0][ELEM_W-1:0] vs1_data;
    logic [LANES-1:0][ELEM_W-1:0] vs2_data;
    logic [LANES-1:0]             mask;
  } vrf_resp_t;

endpackage

// ==== sim.f ====
hw/vrf_cfg_pkg.sv
hw/vrf_types_pkg.sv
hw/vrf_elem_addr.sv
hw/vrf_bank.sv
hw/vrf_read_format.sv
hw/vrf_top.sv
dv/vrf_tb.sv
